// ==== run.sh ====
#!/usr/bin/env bash
# build and run the data_cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_data_cache -f tb.f \
    && ./obj_dir/Vtb_data_cache > sim.log 2>&1 \
    && cat sim.log \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
grep -q "^NO ERRORS$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sim/data_cache_trace.txt ====
// name opcode funct3 address store-data-or-block-seed read-return-word
// all hex, a name of 0 ends the trace
01 03 0 00001000 00000000 12345680 // lb negative byte
02 03 1 00001006 00000000 7f00a5f0 // lh negative halfword
03 03 0 00001001 00000000 8765437f // lb positive byte
04 03 4 00001008 00000000 abcdef9c // lbu
05 03 5 0000100c 00000000 abcd8001 // lhu
06 03 2 00001010 00000000 cafe0123 // lw
07 23 0 00002000 a5a5a5c3 00000000 // sb
08 23 1 00002002 1234beef 00000000 // sh
09 23 2 00002004 deadbeef 00000000 // sw
0a 7f 1 00003000 9bcc93d5 00000000 // block store
0b 33 0 00004000 11111111 00000000 // unknown opcode
0c 7f 2 00004100 22222222 00000000 // block opcode with wrong funct3
0d 7f 0 00004200 33333333 00000000 // block opcode with funct3 0
0e 7f 1 00003040 00000001 00000000 // second block store
0f 03 2 00001014 00000000 80000000 // lw with top bit set
10 23 2 00002008 0badf00d 00000000 // sw after a block
00 00 0 00000000 00000000 00000000 // end of trace

// ==== sim/tb_data_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_data_cache
    import dcache_pkg::*;
();

    localparam int MAX_TESTS    = 32;
    localparam int FIELDS       = 6;
    localparam int RESET_CYCLES = 8;

    logic    clk;
    logic    rst;
    logic    ready;
    opcode_t opcode;
    funct3_t funct3;
    addr_t   addr;
    word_t   wdata;
    block_t  wdata_m;
    logic    busy;
    word_t   rdata;
    logic    rdata_valid;
    addr_t   araddr;
    logic    arvalid;
    logic    arready;
    word_t   rdata_bus;
    logic    rvalid;
    logic    rready;
    addr_t   awaddr;
    logic    awvalid;
    logic    awready;
    word_t   wdata_bus;
    strb_t   wstrb;
    logic    wvalid;
    logic    wready;
    logic    bvalid;
    logic    bready;

    word_t   trace_mem [MAX_TESTS*FIELDS];
    int      n_tests;
    int      limit;
    int      cycles;
    int      test_errs;
    int      pass_cnt;
    int      fail_cnt;
    int      rdv_cnt;
    int      r_cnt;
    int      b_cnt;
    word_t   cur_name;
    word_t   rd_ret;
    addr_t   ar_seen [$];
    bus_wr_t wr_seen [$];
    logic    ar_wait;
    addr_t   ar_hold;
    logic    aw_wait;
    bus_wr_t aw_hold;

    data_cache u_data_cache (.*);

    always #5 clk = ~clk;

    function automatic word_t lcg_next(input word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // 0 to 3 cycles
    function automatic int delay_of(input word_t s);
        return int'(s[17:16]);
    endfunction

    function automatic block_t make_block(input word_t seed);
        block_t b;
        word_t  s;
        s = seed;
        for (int k = 0; k < BLOCK_WORDS; k++) begin
            s = lcg_next(s);
            b[k*32 +: 32] = s;
        end
        return b;
    endfunction

    function automatic word_t load_value(input funct3_t f3, input word_t w);
        int v;
        case (f3)
            F3_LB:   v = $signed(w[7:0]);
            F3_LH:   v = $signed(w[15:0]);
            F3_LBU:  v = int'(w[7:0]);
            F3_LHU:  v = int'(w[15:0]);
            default: v = int'(w);
        endcase
        return word_t'(v);
    endfunction

    function automatic strb_t store_strb(input funct3_t f3);
        strb_t s;
        case (f3)
            F3_SB:   s = 4'b0001;
            F3_SH:   s = 4'b0011;
            default: s = 4'b1111;
        endcase
        return s;
    endfunction

    task automatic note_failure(input string msg);
        $display("test %0h: %s", cur_name, msg);
        test_errs++;
    endtask

    task automatic check_word(input string field, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Error test %0h %s: expected %h, actual %h", cur_name, field, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_addr(input string field, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("Error test %0h %s: expected %h, actual %h", cur_name, field, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_strb(input string field, input strb_t exp, input strb_t act);
        if (act !== exp) begin
            $display("Error test %0h %s: expected %h, actual %h", cur_name, field, exp, act);
            test_errs++;
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the run hung in test %0h after %0d cycles", cur_name, cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // beat capture and payload stability under back-pressure
    always @(posedge clk) begin
        if (!rst) begin
            if (ar_wait && (!arvalid || araddr !== ar_hold)) begin
                note_failure("read address moved before it was accepted");
            end
            if (aw_wait && (!awvalid || bus_wr_t'({awaddr, wdata_bus, wstrb}) !== aw_hold)) begin
                note_failure("write beat moved before it was accepted");
            end
            if (rvalid && !rready) begin
                note_failure("read data came while rready was low");
            end
            if (bvalid && !bready) begin
                note_failure("write response came while bready was low");
            end
            if (arvalid && arready) begin
                ar_seen.push_back(araddr);
            end
            if (rvalid && rready) begin
                r_cnt++;
            end
            if (awvalid && wvalid && awready && wready) begin
                wr_seen.push_back(bus_wr_t'({awaddr, wdata_bus, wstrb}));
            end
            if (bvalid && bready) begin
                b_cnt++;
            end
            if (rdata_valid) begin
                rdv_cnt++;
            end
            ar_wait = arvalid && !arready;
            ar_hold = araddr;
            aw_wait = awvalid && !(awready && wready);
            aw_hold = bus_wr_t'({awaddr, wdata_bus, wstrb});
        end
    end

    initial begin : read_responder
        word_t seed;
        seed = 32'h9bcc93d5;
        forever begin
            @(negedge clk);
            if (!rst && arvalid) begin
                seed = lcg_next(seed);
                repeat (delay_of(seed)) @(negedge clk);
                arready = 1'b1;
                @(negedge clk);
                arready = 1'b0;
                seed = lcg_next(seed);
                repeat (delay_of(seed)) @(negedge clk);
                rdata_bus = rd_ret;
                rvalid = 1'b1;
                @(negedge clk);
                rvalid = 1'b0;
            end
        end
    end

    initial begin : write_responder
        word_t seed;
        seed = lcg_next(32'h9bcc93d5);
        forever begin
            @(negedge clk);
            if (!rst && awvalid) begin
                seed = lcg_next(seed);
                repeat (delay_of(seed)) @(negedge clk);
                awready = 1'b1;
                wready  = 1'b1;
                @(negedge clk);
                awready = 1'b0;
                wready  = 1'b0;
                seed = lcg_next(seed);
                repeat (delay_of(seed)) @(negedge clk);
                bvalid = 1'b1;
                @(negedge clk);
                bvalid = 1'b0;
            end
        end
    end

    task automatic run_test(input int t);
        opcode_t opc;
        funct3_t f3;
        addr_t   a;
        word_t   dat;
        block_t  blk;
        logic    known;
        logic    is_blk;
        logic    counts_ok;
        int      exp_rd;
        int      exp_wr;
        cur_name = trace_mem[t*FIELDS];
        opc      = opcode_t'(trace_mem[t*FIELDS+1]);
        f3       = funct3_t'(trace_mem[t*FIELDS+2]);
        a        = trace_mem[t*FIELDS+3];
        dat      = trace_mem[t*FIELDS+4];
        rd_ret   = trace_mem[t*FIELDS+5];
        blk      = make_block(dat);
        is_blk   = (opc == OPC_BLOCK) && (f3 == F3_BLOCK_MATRIX);
        known    = (opc == OPC_LOAD) || (opc == OPC_STORE) || is_blk;
        exp_rd   = (opc == OPC_LOAD) ? 1 : 0;
        exp_wr   = is_blk ? BLOCK_WORDS : ((opc == OPC_STORE) ? 1 : 0);
        test_errs = 0;
        rdv_cnt   = 0;
        r_cnt     = 0;
        b_cnt     = 0;
        ar_seen.delete();
        wr_seen.delete();
        ready   = 1'b1;
        opcode  = opc;
        funct3  = f3;
        addr    = a;
        wdata   = dat;
        wdata_m = blk;
        @(negedge clk);
        if (known) begin
            if (!busy) begin
                note_failure("the request was not accepted");
            end
            // a second request while busy must be dropped
            opcode  = OPC_STORE;
            funct3  = F3_SW;
            addr    = a ^ 32'h0000_0100;
            wdata   = ~dat;
            wdata_m = ~blk;
            while (busy) @(negedge clk);
            if (r_cnt != exp_rd || b_cnt != exp_wr) begin
                note_failure("busy fell before the last bus response");
            end
        end else if (busy) begin
            note_failure("an ignored request made the port busy");
        end
        ready = 1'b0;
        repeat (4) @(negedge clk);
        counts_ok = 1'b1;
        if (ar_seen.size() != exp_rd || r_cnt != exp_rd || rdv_cnt != exp_rd) begin
            note_failure($sformatf(
                "saw %0d read addresses, %0d read data, %0d results, expected %0d",
                ar_seen.size(), r_cnt, rdv_cnt, exp_rd));
            counts_ok = 1'b0;
        end
        if (wr_seen.size() != exp_wr || b_cnt != exp_wr) begin
            note_failure($sformatf("saw %0d write beats, %0d responses, expected %0d",
                wr_seen.size(), b_cnt, exp_wr));
            counts_ok = 1'b0;
        end
        if (counts_ok) begin
            foreach (ar_seen[i]) begin
                check_addr("araddr", a, ar_seen[i]);
            end
            if (exp_rd == 1) begin
                check_word("rdata", load_value(f3, rd_ret), rdata);
            end
            foreach (wr_seen[k]) begin
                check_addr($sformatf("awaddr beat %0d", k), a + addr_t'(k*WORD_BYTES),
                    wr_seen[k].awaddr);
                check_word($sformatf("wdata_bus beat %0d", k),
                    is_blk ? blk[k*32 +: 32] : dat, wr_seen[k].wdata);
                check_strb($sformatf("wstrb beat %0d", k),
                    is_blk ? 4'b1111 : store_strb(f3), wr_seen[k].wstrb);
            end
        end
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %0h passed", cur_name);
        end else begin
            fail_cnt++;
            $display("test %0h failed with %0d problems", cur_name, test_errs);
        end
    endtask

    initial begin : main
        clk       = 1'b0;
        rst       = 1'b1;
        ready     = 1'b0;
        opcode    = '0;
        funct3    = '0;
        addr      = '0;
        wdata     = '0;
        wdata_m   = '0;
        arready   = 1'b0;
        rvalid    = 1'b0;
        rdata_bus = '0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        cycles    = 0;
        limit     = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        test_errs = 0;
        rdv_cnt   = 0;
        r_cnt     = 0;
        b_cnt     = 0;
        cur_name  = '0;
        rd_ret    = '0;
        ar_wait   = 1'b0;
        aw_wait   = 1'b0;
        for (int i = 0; i < MAX_TESTS*FIELDS; i++) begin
            trace_mem[i] = '0;
        end
        $readmemh("sim/data_cache_trace.txt", trace_mem);
        n_tests = 0;
        while (n_tests < MAX_TESTS && trace_mem[n_tests*FIELDS] != '0) begin
            n_tests++;
        end
        // worst case is a block under full back-pressure
        limit = n_tests * BLOCK_WORDS * 20 + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (n_tests == 0) begin
            $display("the trace file gave no tests");
            fail_cnt++;
        end
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/block_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_buffer
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      blk_load,
    input  block_t    wdata_m,
    input  beat_idx_t beat_idx,
    output word_t     blk_word
);

    word_t words [BLOCK_WORDS];

    // one word per beat in row-major order
    always_ff @(posedge clk) begin
        if (blk_load) begin
            for (int i = 0; i < BLOCK_WORDS; i++) begin
                words[i] <= wdata_m[i*32 +: 32];
            end
        end
    end

    assign blk_word = words[beat_idx];

endmodule

`default_nettype wire

// ==== src/bus_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_sequencer
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  mem_req_t  req,
    input  logic      req_valid,
    input  word_t     blk_word,
    output beat_idx_t beat_idx,
    output logic      seq_busy,
    output bus_wr_t   bus_wr,
    output addr_t     araddr,
    output logic      arvalid,
    input  logic      arready,
    input  word_t     rdata_bus,
    input  logic      rvalid,
    output logic      rready,
    output logic      awvalid,
    input  logic      awready,
    output logic      wvalid,
    input  logic      wready,
    input  logic      bvalid,
    output logic      bready,
    output logic      rd_done,
    output word_t     rd_word,
    output funct3_t   rd_funct3
);

    seq_state_e state;
    mem_req_t   cur;
    beat_idx_t  beat;
    logic       last_beat;
    logic       step_beat;

    assign seq_busy  = (state != seq_idle);
    assign beat_idx  = beat;
    assign last_beat = (cur.kind != op_block_store) ||
                       (beat == beat_idx_t'(BLOCK_WORDS - 1));
    assign step_beat = (state == seq_wr_resp) && bvalid && !last_beat;

    assign araddr        = cur.addr;
    assign bus_wr.awaddr = cur.addr;
    assign bus_wr.wdata  = (cur.kind == op_block_store) ? blk_word : cur.wdata;
    assign bus_wr.wstrb  = cur.strb;

    // data may come with the address acceptance
    assign rd_done   = rready && rvalid && ((state == seq_rd_data) || (arvalid && arready));
    assign rd_word   = rdata_bus;
    assign rd_funct3 = cur.funct3;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= seq_idle;
            beat    <= '0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
        end else begin
            case (state)
                seq_idle: begin
                    if (req_valid) begin
                        beat  <= '0;
                        state <= (req.kind == op_load) ? seq_rd_addr : seq_wr_beat;
                    end
                end
                seq_rd_addr: begin
                    if (!arvalid) begin
                        arvalid <= 1'b1;
                        rready  <= 1'b1;
                    end else if (arready) begin
                        arvalid <= 1'b0;
                        if (rd_done) begin
                            rready <= 1'b0;
                            state  <= seq_idle;
                        end else begin
                            state <= seq_rd_data;
                        end
                    end
                end
                seq_rd_data: begin
                    if (rd_done) begin
                        rready <= 1'b0;
                        state  <= seq_idle;
                    end
                end
                seq_wr_beat: begin
                    if (!awvalid) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        bready  <= 1'b1;
                    end else if (awready && wready) begin
                        awvalid <= 1'b0;
                        wvalid  <= 1'b0;
                        state   <= seq_wr_resp;
                    end
                end
                seq_wr_resp: begin
                    if (bvalid) begin
                        bready <= 1'b0;
                        if (step_beat) begin
                            beat  <= beat + 1'b1;
                            state <= seq_wr_beat;
                        end else begin
                            state <= seq_idle;
                        end
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

    // the address steps once per block beat
    always_ff @(posedge clk) begin
        if (state == seq_idle && req_valid) begin
            cur <= req;
        end else if (step_beat) begin
            cur.addr <= cur.addr + addr_t'(WORD_BYTES);
        end
    end

    a_aw_w_paired: assert property (@(posedge clk) disable iff (rst)
        awvalid == wvalid);

    a_one_channel: assert property (@(posedge clk) disable iff (rst)
        !(arvalid && awvalid));

    // Write payload must not move while the slave is still stalling.
    a_wr_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !(awready && wready) |=> awvalid && $stable(bus_wr));

endmodule

`default_nettype wire

// ==== src/data_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_cache
    import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    // core side
    input  logic    ready,
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  addr_t   addr,
    input  word_t   wdata,
    input  block_t  wdata_m,
    output logic    busy,
    output word_t   rdata,
    output logic    rdata_valid,
    // read channels
    output addr_t   araddr,
    output logic    arvalid,
    input  logic    arready,
    input  word_t   rdata_bus,
    input  logic    rvalid,
    output logic    rready,
    // write channels
    output addr_t   awaddr,
    output logic    awvalid,
    input  logic    awready,
    output word_t   wdata_bus,
    output strb_t   wstrb,
    output logic    wvalid,
    input  logic    wready,
    input  logic    bvalid,
    output logic    bready
);

    mem_req_t  req;
    logic      req_valid;
    logic      blk_load;
    logic      seq_busy;
    beat_idx_t beat_idx;
    word_t     blk_word;
    bus_wr_t   bus_wr;
    logic      rd_done;
    word_t     rd_word;
    funct3_t   rd_funct3;

    req_decode u_req_decode (
        .clk       (clk),
        .rst       (rst),
        .ready     (ready),
        .opcode    (opcode),
        .funct3    (funct3),
        .addr      (addr),
        .wdata     (wdata),
        .seq_busy  (seq_busy),
        .busy      (busy),
        .req       (req),
        .req_valid (req_valid),
        .blk_load  (blk_load)
    );

    block_buffer u_block_buffer (
        .clk      (clk),
        .blk_load (blk_load),
        .wdata_m  (wdata_m),
        .beat_idx (beat_idx),
        .blk_word (blk_word)
    );

    bus_sequencer u_bus_sequencer (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .blk_word  (blk_word),
        .beat_idx  (beat_idx),
        .seq_busy  (seq_busy),
        .bus_wr    (bus_wr),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata_bus (rdata_bus),
        .rvalid    (rvalid),
        .rready    (rready),
        .awvalid   (awvalid),
        .awready   (awready),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready),
        .rd_done   (rd_done),
        .rd_word   (rd_word),
        .rd_funct3 (rd_funct3)
    );

    load_format u_load_format (
        .clk         (clk),
        .rst         (rst),
        .rd_done     (rd_done),
        .rd_word     (rd_word),
        .rd_funct3   (rd_funct3),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    assign awaddr    = bus_wr.awaddr;
    assign wdata_bus = bus_wr.wdata;
    assign wstrb     = bus_wr.wstrb;

endmodule

`default_nettype wire

// ==== src/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    typedef logic [31:0]  word_t;
    typedef logic [31:0]  addr_t;
    typedef logic [3:0]   strb_t;
    // row-major with word 0 in the low bits
    typedef logic [511:0] block_t;
    typedef logic [3:0]   beat_idx_t;
    typedef logic [6:0]   opcode_t;
    typedef logic [2:0]   funct3_t;

    localparam int BLOCK_WORDS = 16;
    localparam int WORD_BYTES  = 4;

    localparam opcode_t OPC_LOAD  = 7'b0000011;
    localparam opcode_t OPC_STORE = 7'b0100011;
    localparam opcode_t OPC_BLOCK = 7'b1111111;

    localparam funct3_t F3_BLOCK_MATRIX = 3'b001;

    // base integer loads
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // base integer stores
    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

    typedef enum logic [1:0] {
        op_load,
        op_store,
        op_block_store
    } op_kind_e;

    typedef struct packed {
        op_kind_e kind;
        addr_t    addr;
        word_t    wdata;
        strb_t    strb;
        funct3_t  funct3;
    } mem_req_t;

    typedef enum logic [2:0] {
        seq_idle,
        seq_rd_addr,
        seq_rd_data,
        seq_wr_beat,
        seq_wr_resp
    } seq_state_e;

    // write address, data and strobe travel together
    typedef struct packed {
        addr_t awaddr;
        word_t wdata;
        strb_t wstrb;
    } bus_wr_t;

endpackage

`default_nettype wire

// ==== src/load_format.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_format
    import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    rd_done,
    input  word_t   rd_word,
    input  funct3_t rd_funct3,
    output word_t   rdata,
    output logic    rdata_valid
);

    word_t ext;

    always_comb begin
        case (rd_funct3)
            F3_LB:   ext = {{24{rd_word[7]}}, rd_word[7:0]};
            F3_LH:   ext = {{16{rd_word[15]}}, rd_word[15:0]};
            F3_LBU:  ext = {24'b0, rd_word[7:0]};
            F3_LHU:  ext = {16'b0, rd_word[15:0]};
            // lw and anything else
            default: ext = rd_word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= rd_done;
        end
    end

    // held until the next load
    always_ff @(posedge clk) begin
        if (rd_done) begin
            rdata <= ext;
        end
    end

endmodule

`default_nettype wire

// ==== src/req_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_decode
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     ready,
    input  opcode_t  opcode,
    input  funct3_t  funct3,
    input  addr_t    addr,
    input  word_t    wdata,
    input  logic     seq_busy,
    output logic     busy,
    output mem_req_t req,
    output logic     req_valid,
    output logic     blk_load
);

    op_kind_e kind_d;
    logic     known;
    strb_t    strb_d;
    logic     pending;
    logic     accept;

    always_comb begin
        kind_d = op_load;
        known  = 1'b0;
        case (opcode)
            OPC_LOAD: begin
                kind_d = op_load;
                known  = 1'b1;
            end
            OPC_STORE: begin
                kind_d = op_store;
                known  = 1'b1;
            end
            OPC_BLOCK: begin
                kind_d = op_block_store;
                // only the full-matrix form is supported
                known  = (funct3 == F3_BLOCK_MATRIX);
            end
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        strb_d = 4'b0000;
        if (kind_d == op_block_store) begin
            strb_d = 4'b1111;
        end else if (kind_d == op_store) begin
            case (funct3)
                F3_SB:   strb_d = 4'b0001;
                F3_SH:   strb_d = 4'b0011;
                default: strb_d = 4'b1111;
            endcase
        end
    end

    assign busy     = pending || seq_busy;
    assign accept   = ready && !busy && known;
    assign blk_load = accept && (kind_d == op_block_store);
    assign req_valid = pending;

    // pending covers the cycle before the sequencer leaves idle
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else begin
            pending <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req.kind   <= kind_d;
            req.addr   <= addr;
            req.wdata  <= wdata;
            req.strb   <= strb_d;
            req.funct3 <= funct3;
        end
    end

    // a new request may only reach an idle sequencer
    a_req_into_idle: assert property (@(posedge clk) disable iff (rst)
        !(req_valid && seq_busy));

endmodule

`default_nettype wire

// ==== tb.f ====
src/dcache_pkg.sv
src/req_decode.sv
src/block_buffer.sv
src/bus_sequencer.sv
src/load_format.sv
src/data_cache.sv
sim/tb_data_cache.sv
